// File: logic/tlast_link_defs.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tlast link constants
// widths, escape code and APB register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TLAST_LINK_DEFS_SVH
`define TLAST_LINK_DEFS_SVH

`define TLL_DATA_W 64                       // link and stream word
`define TLL_CSUM_W 32                       // half word, running sum
`define TLL_CNT_W  16                       // event counters

`define TLL_ESC_WORD 64'hDEADBEEFFEEDCAFE   // in-band escape code

// apb byte offsets
`define TLL_REG_CTRL        8'h00
`define TLL_REG_TX_PKTS     8'h04
`define TLL_REG_TX_ESC      8'h08
`define TLL_REG_RX_PKTS     8'h0C
`define TLL_REG_RX_CSUM_ERR 8'h10

`endif

// File: logic/tlast_link_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tlast link types
// word, stream beat, event and stats types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "tlast_link_defs.svh"

package tlast_link_pkg;
   typedef logic [`TLL_DATA_W-1:0] data_t;   // one link word
   typedef logic [`TLL_CSUM_W-1:0] csum_t;   // sum of word halves
   typedef logic [`TLL_CNT_W-1:0]  cnt_t;

   // user stream word, 65 bits
   typedef struct packed {
      data_t tdata;
      logic  tlast;
   } axis_beat_t;

   // single cycle pulses, order matches link_stats_t
   typedef struct packed {
      logic tx_pkt;
      logic tx_esc;
      logic rx_pkt;
      logic rx_csum_err;
   } link_events_t;

   typedef struct packed {
      cnt_t tx_pkts;
      cnt_t tx_esc;
      cnt_t rx_pkts;
      cnt_t rx_csum_err;
   } link_stats_t;

   typedef enum logic [1:0] {EMB_IDLE, EMB_MARK_LAST, EMB_MARK_ESC, EMB_FINISH} embed_state_e;
   typedef enum logic [1:0] {EXT_IDLE, EXT_MARKER, EXT_PAYLOAD} extract_state_e;
endpackage

// File: logic/tlast_embed_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tlast embed, transmit side
// inserts escape and marker words in band
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "tlast_link_defs.svh"

module tlast_embed_fsm (
   input  logic                       clk,
   input  logic                       i_reset,
   input  logic                       i_clear,
   input  tlast_link_pkg::axis_beat_t i_beat,
   input  logic                       i_valid,
   output logic                       o_ready,
   output tlast_link_pkg::data_t      o_word,
   output logic                       o_valid,
   input  logic                       i_ready,
   output logic                       o_tx_pkt,
   output logic                       o_tx_esc
);
   import tlast_link_pkg::*;

   embed_state_e state, next_state;
   csum_t        csum;        // sum over accepted words of this packet
   logic         pass;        // user word drives the link
   logic         accept;      // user word taken
   logic         is_esc;

   assign is_esc = (i_beat.tdata == `TLL_ESC_WORD);
   assign accept = i_valid && o_ready;

   // advance only when the link takes the word
   always_ff @(posedge clk) begin
      if (i_reset || i_clear) begin
         state <= EMB_IDLE;
      end else if (i_ready) begin
         state <= next_state;
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset || i_clear) begin
         csum <= '0;
      end else if (accept && i_beat.tlast) begin
         csum <= '0;                                  // packet done, restart
      end else if (accept) begin
         csum <= csum + i_beat.tdata[`TLL_CSUM_W-1:0]
                      + i_beat.tdata[`TLL_DATA_W-1:`TLL_CSUM_W];
      end
   end

   always_comb begin
      next_state = state;
      pass       = 1'b0;
      o_word     = i_beat.tdata;
      case (state)
         EMB_IDLE: begin
            if (i_valid && i_beat.tlast) begin        // last wins over escape match
               next_state = EMB_MARK_LAST;
               o_word     = `TLL_ESC_WORD;
            end else if (i_valid && is_esc) begin
               next_state = EMB_MARK_ESC;
               o_word     = `TLL_ESC_WORD;
            end else begin
               pass = 1'b1;                           // plain word, same cycle
            end
         end
         EMB_MARK_LAST: begin
            next_state = EMB_FINISH;
            o_word     = {csum, {(`TLL_DATA_W-`TLL_CSUM_W-1){1'b0}}, 1'b1};
         end
         EMB_MARK_ESC: begin
            next_state = EMB_FINISH;
            o_word     = '0;                          // zero marker
         end
         EMB_FINISH: begin
            pass = 1'b1;                              // the held word itself
            if (i_valid) next_state = EMB_IDLE;
         end
         default: next_state = EMB_IDLE;
      endcase
   end

   assign o_valid = pass ? i_valid : 1'b1;            // inserted words always valid
   assign o_ready = pass ? i_ready : 1'b0;            // hold user word until third beat

   // events on the third beat
   assign o_tx_pkt = accept && (state == EMB_FINISH) && i_beat.tlast;
   assign o_tx_esc = accept && (state == EMB_FINISH) && is_esc;
endmodule

// File: logic/tlast_extract.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tlast extract, receive side
// strips escape and marker, restores last
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "tlast_link_defs.svh"

module tlast_extract (
   input  logic                       clk,
   input  logic                       i_reset,
   input  logic                       i_clear,
   input  tlast_link_pkg::data_t      i_word,
   input  logic                       i_valid,
   output logic                       o_ready,
   output tlast_link_pkg::axis_beat_t o_beat,
   output logic                       o_valid,
   input  logic                       i_ready,
   output logic                       o_rx_pkt,
   output logic                       o_rx_csum_err
);
   import tlast_link_pkg::*;

   extract_state_e state;
   csum_t          csum;       // local sum, words passed with last low
   logic           pend_last;  // from marker bit 0
   logic           is_esc;
   logic           accept;     // link word consumed
   logic           take;       // user word delivered

   assign is_esc = (i_word == `TLL_ESC_WORD);
   assign accept = i_valid && o_ready;
   assign take   = o_valid && i_ready;

   always_comb begin
      o_beat.tdata = i_word;
      o_beat.tlast = 1'b0;
      o_valid      = i_valid;
      o_ready      = i_ready;                         // payload follows downstream
      case (state)
         EXT_IDLE: begin
            if (is_esc) begin                         // swallow escape
               o_valid = 1'b0;
               o_ready = 1'b1;
            end
         end
         EXT_MARKER: begin                            // swallow marker
            o_valid = 1'b0;
            o_ready = 1'b1;
         end
         EXT_PAYLOAD: o_beat.tlast = pend_last;
         default: o_valid = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_reset || i_clear) begin
         state     <= EXT_IDLE;
         pend_last <= 1'b0;
      end else if (accept) begin
         case (state)
            EXT_IDLE: begin
               if (is_esc) state <= EXT_MARKER;
            end
            EXT_MARKER: begin
               state     <= EXT_PAYLOAD;
               pend_last <= i_word[0];
            end
            default: state <= EXT_IDLE;               // payload sent
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset || i_clear) begin
         csum <= '0;
      end else if (take && o_beat.tlast) begin
         csum <= '0;
      end else if (take) begin
         csum <= csum + i_word[`TLL_CSUM_W-1:0] + i_word[`TLL_DATA_W-1:`TLL_CSUM_W];
      end
   end

   assign o_rx_pkt      = take && o_beat.tlast;
   // last marker carries tx sum in upper half
   assign o_rx_csum_err = accept && (state == EXT_MARKER) && i_word[0]
                          && (i_word[`TLL_DATA_W-1:`TLL_CSUM_W] != csum);
endmodule

// File: logic/link_event_counters.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// link event counters
// four saturating counts of link events
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module link_event_counters (
   input  logic                         clk,
   input  logic                         i_reset,
   input  logic                         i_clear,
   input  tlast_link_pkg::link_events_t i_events,
   output tlast_link_pkg::link_stats_t  o_stats
);
   import tlast_link_pkg::*;

   localparam int N_EV = 4;

   logic [N_EV-1:0] ev;           // pulses, same field order as stats
   cnt_t [N_EV-1:0] cnt;

   assign ev      = i_events;
   assign o_stats = cnt;

   always_ff @(posedge clk) begin
      if (i_reset || i_clear) begin
         cnt <= '0;
      end else begin
         for (int i = 0; i < N_EV; i++) begin
            if (ev[i] && (cnt[i] != '1)) begin      // stick at max
               cnt[i] <= cnt[i] + 1'b1;
            end
         end
      end
   end
endmodule

// File: logic/link_apb_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// link APB registers
// control and counter readback, no waits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "tlast_link_defs.svh"

module link_apb_regs (
   input  logic                        clk,
   input  logic                        i_reset,
   input  logic                        i_psel,
   input  logic                        i_penable,
   input  logic                        i_pwrite,
   input  logic [7:0]                  i_paddr,
   input  logic [31:0]                 i_pwdata,
   output logic [31:0]                 o_prdata,
   output logic                        o_pready,
   output logic                        o_pslverr,
   input  tlast_link_pkg::link_stats_t i_stats,
   output logic                        o_clear
);
   localparam int PAD = 32 - `TLL_CNT_W;

   logic access;     // apb access phase
   logic hit;        // mapped offset

   assign access   = i_psel && i_penable;
   assign o_pready = 1'b1;                     // zero wait states

   always_comb begin
      hit      = 1'b1;
      o_prdata = '0;
      case (i_paddr)
         `TLL_REG_CTRL:        o_prdata = '0;  // clear is self resetting
         `TLL_REG_TX_PKTS:     o_prdata = {{PAD{1'b0}}, i_stats.tx_pkts};
         `TLL_REG_TX_ESC:      o_prdata = {{PAD{1'b0}}, i_stats.tx_esc};
         `TLL_REG_RX_PKTS:     o_prdata = {{PAD{1'b0}}, i_stats.rx_pkts};
         `TLL_REG_RX_CSUM_ERR: o_prdata = {{PAD{1'b0}}, i_stats.rx_csum_err};
         default:              hit = 1'b0;
      endcase
   end

   assign o_pslverr = access && !hit;

   // one cycle soft clear after the write
   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_clear <= 1'b0;
      end else begin
         o_clear <= access && i_pwrite && (i_paddr == `TLL_REG_CTRL) && i_pwdata[0];
      end
   end
endmodule

// File: logic/tlast_link_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tlast link top
// embed, extract, counters and APB regs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tlast_link_top (
   input  logic                       clk,
   input  logic                       i_reset,
   input  logic                       i_psel,
   input  logic                       i_penable,
   input  logic                       i_pwrite,
   input  logic [7:0]                 i_paddr,
   input  logic [31:0]                i_pwdata,
   output logic [31:0]                o_prdata,
   output logic                       o_pready,
   output logic                       o_pslverr,
   input  tlast_link_pkg::axis_beat_t i_s_beat,
   input  logic                       i_s_valid,
   output logic                       o_s_ready,
   output tlast_link_pkg::data_t      o_link_word,
   output logic                       o_link_valid,
   input  logic                       i_link_ready,
   input  tlast_link_pkg::data_t      i_link_word,
   input  logic                       i_link_valid,
   output logic                       o_link_ready,
   output tlast_link_pkg::axis_beat_t o_m_beat,
   output logic                       o_m_valid,
   input  logic                       i_m_ready
);
   import tlast_link_pkg::*;

   link_events_t events;     // pulses from both sides
   link_stats_t  stats;
   logic         clear;      // soft clear from CTRL

   tlast_embed_fsm u_embed (
      .clk, .i_reset, .i_clear(clear),
      .i_beat(i_s_beat), .i_valid(i_s_valid), .o_ready(o_s_ready),
      .o_word(o_link_word), .o_valid(o_link_valid), .i_ready(i_link_ready),
      .o_tx_pkt(events.tx_pkt), .o_tx_esc(events.tx_esc)
   );

   tlast_extract u_extract (
      .clk, .i_reset, .i_clear(clear),
      .i_word(i_link_word), .i_valid(i_link_valid), .o_ready(o_link_ready),
      .o_beat(o_m_beat), .o_valid(o_m_valid), .i_ready(i_m_ready),
      .o_rx_pkt(events.rx_pkt), .o_rx_csum_err(events.rx_csum_err)
   );

   link_event_counters u_counters (
      .clk, .i_reset, .i_clear(clear), .i_events(events), .o_stats(stats)
   );

   link_apb_regs u_regs (
      .clk, .i_reset,
      .i_psel, .i_penable, .i_pwrite, .i_paddr, .i_pwdata,
      .o_prdata, .o_pready, .o_pslverr,
      .i_stats(stats), .o_clear(clear)
   );
endmodule

// File: dv/tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset source
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_clock_gen #(
   parameter real PERIOD_NS    = 100.0,
   parameter int  RESET_CYCLES = 10
) (
   output logic clk,
   output logic o_reset
);
   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2.0) clk = ~clk;
   end

   initial begin
      o_reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 o_reset = 1'b0;                  // released like any other input
   end
endmodule

// File: dv/tlast_link_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tlast link testbench, loopback with
// corruption hook, scoreboard and APB checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "tlast_link_defs.svh"

module tlast_link_tb;
   import tlast_link_pkg::*;

   localparam data_t CORRUPT_WORD = 64'h0123_4567_89AB_CDEF;   // only ever sent once

   logic        clk;
   logic        reset;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [7:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   axis_beat_t  s_beat;
   logic        s_valid;
   logic        s_ready;
   data_t       link_word;        // DUT link out
   data_t       link_in;          // after the hook
   logic        link_valid;
   logic        link_ready;
   axis_beat_t  m_beat;
   logic        m_valid;
   logic        m_ready;

   integer     seed = 30310;
   int         errors, err_base, tests_failed, cycles;
   int         link_beats;        // link words the queued stimulus needs
   int         n_pkts, n_esc;
   int         one_marks, zero_marks;
   int         lk_st;             // 0 idle, 1 marker next, 2 payload next
   bit         lk_last;
   bit         flip_armed, rand_mready;
   csum_t      tb_sum;            // sum of halves, user side
   axis_beat_t stim_q[$];
   axis_beat_t exp_q[$];

   tb_clock_gen #(.PERIOD_NS(100.0), .RESET_CYCLES(10)) u_clock_gen (.clk, .o_reset(reset));

   // loopback, bit 0 flips on the marked word
   assign link_in = link_word ^ ((flip_armed && link_word == CORRUPT_WORD) ? 64'd1 : 64'd0);

   tlast_link_top u_tlast_link_top (
      .clk, .i_reset(reset),
      .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite), .i_paddr(paddr),
      .i_pwdata(pwdata), .o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr),
      .i_s_beat(s_beat), .i_s_valid(s_valid), .o_s_ready(s_ready),
      .o_link_word(link_word), .o_link_valid(link_valid), .i_link_ready(link_ready),
      .i_link_word(link_in), .i_link_valid(link_valid), .o_link_ready(link_ready),
      .o_m_beat(m_beat), .o_m_valid(m_valid), .i_m_ready(m_ready)
   );

   task automatic report_mismatch(input string msg);
      $display("MISMATCH at %0t ns: %s", $time, msg);
      errors++;
   endtask

   // stalled words hold until taken
   assert property (@(posedge clk) disable iff (reset)
      (link_valid && !link_ready) |=> (link_valid && $stable(link_word)))
      else report_mismatch("link word changed while stalled");
   assert property (@(posedge clk) disable iff (reset)
      (m_valid && !m_ready) |=> (m_valid && $stable(m_beat)))
      else report_mismatch("output beat changed while stalled");

   always @(posedge clk) begin
      cycles++;
      if (cycles > 4 * link_beats + 200) begin
         $display("timeout after %0d cycles, the streams stopped moving", cycles);
         $display("sim failed");
         $finish;
      end
   end

   always @(posedge clk) begin
      #1 m_ready = rand_mready ? ($random(seed) % 2 != 0) : 1'b1;
   end

   // all checks at negedge, where every signal is settled
   always @(negedge clk) begin : monitor
      axis_beat_t exp;
      if (reset) begin
         lk_st  = 0;
         tb_sum = '0;
      end else begin
         if (link_valid && link_ready) begin
            case (lk_st)
               0: if (link_word == `TLL_ESC_WORD) begin
                     assert (s_valid && !s_ready && (s_beat.tlast || s_beat.tdata == `TLL_ESC_WORD))
                        else report_mismatch("escape word without a marked user word");
                     lk_last = s_beat.tlast;
                     lk_st   = 1;
                  end else begin
                     assert (s_valid && s_ready && !s_beat.tlast && link_word == s_beat.tdata)
                        else report_mismatch($sformatf("plain link word %h", link_word));
                  end
               1: begin
                  if (lk_last) begin                  // sum of earlier words, flag set
                     assert (link_word == {tb_sum, 31'd0, 1'b1})
                        else report_mismatch($sformatf("last marker %h sum %h", link_word, tb_sum));
                     one_marks++;
                  end else begin
                     assert (link_word == '0) else report_mismatch("escape marker not zero");
                     zero_marks++;
                  end
                  lk_st = 2;
               end
               default: begin
                  assert (s_valid && s_ready && link_word == s_beat.tdata)
                     else report_mismatch($sformatf("payload %h after marker", link_word));
                  lk_st = 0;
               end
            endcase
         end
         if (s_valid && s_ready) begin
            tb_sum = s_beat.tlast ? '0 : tb_sum + s_beat.tdata[31:0] + s_beat.tdata[63:32];
         end
         if (m_valid && m_ready) begin
            if (exp_q.size() == 0) begin
               $display("output word %h arrived with nothing expected", m_beat.tdata);
               errors++;
            end else begin
               exp = exp_q.pop_front();
               assert (m_beat == exp)
                  else report_mismatch($sformatf("out %h/%b, expected %h/%b",
                                       m_beat.tdata, m_beat.tlast, exp.tdata, exp.tlast));
            end
         end
      end
   end

   task automatic queue_beat(input data_t w, input logic last);
      axis_beat_t b;
      b.tdata = w;
      b.tlast = last;
      stim_q.push_back(b);
      if (flip_armed && w == CORRUPT_WORD) b.tdata = w ^ 64'd1;   // arrives corrupted
      exp_q.push_back(b);
      link_beats += (last || w == `TLL_ESC_WORD) ? 3 : 1;
      if (last) n_pkts++;
      if (w == `TLL_ESC_WORD) n_esc++;
   endtask

   task automatic make_pkt(input int len, input bit corrupt);
      data_t w;
      for (int i = 0; i < len; i++) begin
         w = {$random(seed), $random(seed)};
         if (($random(seed) & 3) == 0) w = `TLL_ESC_WORD;    // about one in four
         if (corrupt && i == 0) w = CORRUPT_WORD;
         queue_beat(w, i == len - 1);
      end
   endtask

   task automatic send_stream(input bit gaps);
      bit fire;
      while (stim_q.size() != 0) begin
         if (gaps && ($random(seed) % 3 == 0)) begin
            s_valid = 1'b0;                             // idle cycle
            @(posedge clk);
            #1;
         end else begin
            s_beat  = stim_q.pop_front();
            s_valid = 1'b1;
            fire    = 1'b0;
            while (!fire) begin
               @(negedge clk);
               fire = s_ready;
               @(posedge clk);
               #1;
            end
         end
      end
      s_valid = 1'b0;
   endtask

   task automatic wait_drain;
      while (exp_q.size() != 0) begin
         @(posedge clk);
         #1;
      end
      @(posedge clk);                                   // counters lag one cycle
      #1;
   endtask

   task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge clk);
      #1 penable = 1'b1;
      @(negedge clk);
      rdata = prdata;
      err   = pslverr;
      assert (pready) else report_mismatch("pready low in access phase");
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic read_check(input logic [7:0] addr, input int expected);
      logic [31:0] rd;
      logic        err;
      apb_access(1'b0, addr, 32'd0, rd, err);
      assert (rd == expected && !err)
         else report_mismatch($sformatf("reg %h read %0d err %b, expected %0d", addr, rd, err,
                                        expected));
   endtask

   task automatic soft_clear;
      logic [31:0] rd;
      logic        err;
      apb_access(1'b1, `TLL_REG_CTRL, 32'd1, rd, err);
      @(posedge clk);                                   // clear lands on this edge
      #1;
   endtask

   task automatic end_test(input int num, input string name);
      if (errors == err_base) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         $display("test %0d %s: FAILED with %0d errors", num, name, errors - err_base);
         tests_failed++;
      end
      err_base = errors;
   endtask

   initial begin
      logic [31:0] rd;
      logic        err;
      int          marks;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      s_beat = '0;
      s_valid = 1'b0;
      m_ready = 1'b1;
      @(posedge clk);
      while (reset) @(posedge clk);
      @(negedge clk);
      assert (!link_valid && !m_valid && s_ready && !pslverr)
         else report_mismatch("outputs wrong after reset");
      @(posedge clk);
      #1 err_base = errors;

      for (int p = 0; p < 6; p++) make_pkt(1 + ($random(seed) & 3), 1'b0);
      queue_beat(64'h1111_2222_3333_4444, 1'b0);          // forced mix
      queue_beat(`TLL_ESC_WORD, 1'b0);
      queue_beat(64'h5555_6666_7777_8888, 1'b1);
      send_stream(1'b0);
      wait_drain();
      end_test(1, "round trip");

      marks = one_marks;
      for (int p = 0; p < 4; p++) make_pkt(2 + p, 1'b0);
      send_stream(1'b0);
      wait_drain();
      assert (one_marks - marks == 4) else report_mismatch("last markers missing on the link");
      end_test(2, "encoding of last");

      marks = zero_marks;
      queue_beat(`TLL_ESC_WORD, 1'b0);
      queue_beat(`TLL_ESC_WORD, 1'b0);
      queue_beat(64'h0000_0000_0000_0042, 1'b1);
      queue_beat(`TLL_ESC_WORD, 1'b1);                    // last wins, one-marker
      send_stream(1'b0);
      wait_drain();
      assert (zero_marks - marks == 2) else report_mismatch("zero markers missing on the link");
      end_test(3, "escape data");

      rand_mready = 1'b1;
      for (int p = 0; p < 8; p++) make_pkt(1 + ($random(seed) & 7), 1'b0);
      send_stream(1'b1);
      wait_drain();
      rand_mready = 1'b0;
      end_test(4, "back-pressure");

      soft_clear();
      n_pkts = 0;
      n_esc = 0;
      flip_armed = 1'b1;
      make_pkt(3, 1'b1);
      make_pkt(4, 1'b0);
      make_pkt(2, 1'b0);
      send_stream(1'b0);
      wait_drain();
      flip_armed = 1'b0;
      read_check(`TLL_REG_RX_CSUM_ERR, 1);
      read_check(`TLL_REG_TX_PKTS, n_pkts);
      read_check(`TLL_REG_RX_PKTS, n_pkts);
      read_check(`TLL_REG_TX_ESC, n_esc);
      end_test(5, "checksum error");

      soft_clear();
      read_check(`TLL_REG_CTRL, 0);
      read_check(`TLL_REG_TX_PKTS, 0);
      read_check(`TLL_REG_TX_ESC, 0);
      read_check(`TLL_REG_RX_PKTS, 0);
      read_check(`TLL_REG_RX_CSUM_ERR, 0);
      apb_access(1'b0, 8'h20, 32'd0, rd, err);
      assert (err) else report_mismatch("no pslverr on unmapped offset 0x20");
      end_test(6, "registers");

      $display("tests run: 6, failed: %0d, errors: %0d", tests_failed, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end
endmodule

// File: tlast_link.f
+incdir+logic
logic/tlast_link_pkg.sv
logic/tlast_embed_fsm.sv
logic/tlast_extract.sv
logic/link_event_counters.sv
logic/link_apb_regs.sv
logic/tlast_link_top.sv
dv/tb_clock_gen.sv
dv/tlast_link_tb.sv

// File: Bender.yml
package:
  name: tlast_link

sources:
  - include_dirs:
      - logic
    files:
      - logic/tlast_link_pkg.sv
      - logic/tlast_embed_fsm.sv
      - logic/tlast_extract.sv
      - logic/link_event_counters.sv
      - logic/link_apb_regs.sv
      - logic/tlast_link_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/tb_clock_gen.sv
      - dv/tlast_link_tb.sv
